/* sim.f */
+incdir+src
src/umi_pkg.sv
src/mem_pkg.sv
src/umi_unpack.sv
src/umi_pack.sv
src/umi_endpoint.sv
src/umi_regmem.sv
src/umi_mem_top.sv
testbench/umi_endpoint_sva.sv
testbench/tb_umi_mem.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --top-module tb_umi_mem -f sim.f -o tb_umi_mem \
   && ./obj_dir/tb_umi_mem | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
   && exit 0 \
   || exit 1

/* testbench/tb_umi_mem.sv */
// testbench for the UMI memory subsystem: LCG random reads and writes checked against a model
`include "umi_defines.svh"

module tb_umi_mem;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_SWEEP  = `UMI_MEM_WORDS;     // read every word after reset
   localparam int NUM_REQ    = NUM_SWEEP + 400;    // plus the random requests
   localparam int MAX_CYCLES = NUM_REQ * 4 + 100;

   logic clk, nreset, udev_req_valid, udev_req_ready;
   logic udev_resp_valid, udev_resp_ready;
   logic [`UMI_UW-1:0] udev_req_packet, udev_resp_packet;

   logic [`UMI_DW-1:0] model [`UMI_MEM_WORDS];          // reference memory
   logic [31:0] exp_hdr_q[$], exp_dst_q[$], exp_data_q[$];   // responses still owed
   logic [31:0] rng_state;
   logic        cur_write, last_write, last_read, fired;
   logic [3:0]  cur_index, cur_size;
   logic [19:0] cur_opts;
   logic [31:0] cur_src, cur_data;
   int          errors, writes, reads, responses, sent, cycle_count;

   umi_mem_top umi_mem_top_i (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // packet word by slot, slot 0 in the low bits
   function automatic logic [31:0] slot_word(logic [`UMI_UW-1:0] pkt, umi_pkg::umi_word_e slot);
      return pkt[int'(slot) * `UMI_DW +: `UMI_DW];
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got, exp);
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      errors++;
   endtask

   //############################################################
   // stimulus
   //############################################################

   task automatic new_request(input logic is_write, input logic [3:0] index);
      umi_pkg::umi_header_u hdr;
      logic [31:0]          r;
      r         = lcg_next();
      cur_write = is_write;
      cur_index = index;
      cur_size  = r[3:0];      // echoed back, so any value will do
      cur_opts  = r[31:12];
      cur_src   = lcg_next();
      cur_data  = lcg_next();
      r         = lcg_next();   // junk in the unused address bits
      hdr.word  = {cur_opts, cur_size, is_write ? `UMI_REQ_WRITE : `UMI_REQ_READ};
      udev_req_packet[int'(umi_pkg::word_hdr) * `UMI_DW +: `UMI_DW]  = hdr.word;
      udev_req_packet[int'(umi_pkg::word_dst) * `UMI_DW +: `UMI_DW]  = {r[31:6], index, 2'b00};
      udev_req_packet[int'(umi_pkg::word_src) * `UMI_DW +: `UMI_DW]  = cur_src;
      udev_req_packet[int'(umi_pkg::word_data) * `UMI_DW +: `UMI_DW] = cur_data;
      udev_req_valid = 1'b1;
   endtask

   // next inputs, a request not yet taken stays put
   task automatic drive(input logic fired);
      logic [31:0] r;
      if (fired || !udev_req_valid)
      begin
         r = lcg_next();
         if (sent < NUM_SWEEP)
            new_request(1'b0, sent[3:0]);   // sweep reads
         else if (sent < NUM_REQ)
            new_request(r[31], r[27:24]);
         else
            udev_req_valid = 1'b0;
      end
      r = lcg_next();
      udev_resp_ready = (sent < NUM_SWEEP || sent >= NUM_REQ) ? 1'b1 : (r[31:30] != 2'b00);
   endtask

   //############################################################
   // checks, just after the falling edge once the inputs have settled
   //############################################################

   // handshakes seen here complete at the coming rising edge
   task automatic observe(output logic req_fire);
      umi_pkg::umi_header_u exp_hdr;
      logic                 resp_fire;
      req_fire  = udev_req_valid & udev_req_ready;
      resp_fire = udev_resp_valid & udev_resp_ready;
      if (last_write && udev_req_ready)   // memory still committing
         report_mismatch("udev_req_ready", 32'(udev_req_ready), 32'd0);
      if (last_read && !udev_resp_valid)   // one cycle read latency
         report_mismatch("udev_resp_valid", 32'(udev_resp_valid), 32'd1);
      if (resp_fire && exp_hdr_q.size() == 0)
      begin
         $display("response taken with no read outstanding at %0t", $time);
         errors++;
      end
      else if (resp_fire)
      begin
         exp_hdr.word = exp_hdr_q.pop_front();
         if (slot_word(udev_resp_packet, umi_pkg::word_hdr) != exp_hdr.word)
            report_mismatch("udev_resp_packet header",
                            slot_word(udev_resp_packet, umi_pkg::word_hdr), exp_hdr.word);
         if (slot_word(udev_resp_packet, umi_pkg::word_dst) != exp_dst_q[0])
            report_mismatch("udev_resp_packet dstaddr",
                            slot_word(udev_resp_packet, umi_pkg::word_dst), exp_dst_q[0]);
         if (slot_word(udev_resp_packet, umi_pkg::word_src) != 32'd0)
            report_mismatch("udev_resp_packet srcaddr",
                            slot_word(udev_resp_packet, umi_pkg::word_src), 32'd0);
         if (slot_word(udev_resp_packet, umi_pkg::word_data) != exp_data_q[0])
            report_mismatch("udev_resp_packet data",
                            slot_word(udev_resp_packet, umi_pkg::word_data), exp_data_q[0]);
         void'(exp_dst_q.pop_front());
         void'(exp_data_q.pop_front());
         responses++;
      end
      if (req_fire && cur_write)
      begin
         model[cur_index] = cur_data;
         writes++;
      end
      else if (req_fire)
      begin
         exp_hdr.word = {cur_opts, cur_size, `UMI_RESP_READ};
         exp_hdr_q.push_back(exp_hdr.word);
         exp_dst_q.push_back(cur_src);          // reply goes to the requester
         exp_data_q.push_back(model[cur_index]);
         reads++;
      end
      sent       = sent + int'(req_fire);
      last_write = req_fire & cur_write;
      last_read  = req_fire & ~cur_write;
   endtask

   //############################################################
   // main sequence
   //############################################################

   initial
   begin
      rng_state       = 32'hd007;
      clk             = 1'b0;
      nreset          = 1'b0;
      udev_req_valid  = 1'b0;
      udev_req_packet = '0;
      udev_resp_ready = 1'b0;
      cur_write       = 1'b0;
      last_write      = 1'b0;
      last_read       = 1'b0;
      for (int i = 0; i < `UMI_MEM_WORDS; i++)
         model[i] = '0;   // memory comes up zero
      repeat (3) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      if (udev_resp_valid)
         report_mismatch("udev_resp_valid", 32'(udev_resp_valid), 32'd0);
      drive(1'b0);
      while (sent < NUM_REQ || exp_hdr_q.size() != 0)
      begin
         #1;   // ready settles after the new inputs
         observe(fired);
         @(negedge clk);
         drive(fired);
      end
      if (responses != reads)
      begin
         $display("%0d responses for %0d accepted reads", responses, reads);
         errors++;
      end
      $display("writes %0d, reads %0d, responses %0d, errors %0d", writes, reads, responses, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // run limit
   initial
   begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles with %0d of %0d requests accepted",
               cycle_count, sent, NUM_REQ);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

/* testbench/umi_endpoint_sva.sv */
// device-port handshake assertions, bound into the endpoint
`include "umi_defines.svh"

module umi_endpoint_sva
  (
   input logic               clk,
   input logic               nreset,
   input logic               udev_req_ready,
   input logic               udev_resp_valid,
   input logic [`UMI_UW-1:0] udev_resp_packet,
   input logic               udev_resp_ready
   );

   timeunit 1ns;
   timeprecision 100ps;

   // stalled response stays valid and unchanged
   resp_held: assert property (@(posedge clk) disable iff (!nreset)
      udev_resp_valid && !udev_resp_ready |=> udev_resp_valid && $stable(udev_resp_packet))
      else $error("response dropped or changed while stalled");

   resp_idle_in_reset: assert property (@(posedge clk) !nreset |-> !udev_resp_valid)
      else $error("response valid during reset");

   // no new request while a response cannot leave
   req_blocked: assert property (@(posedge clk) disable iff (!nreset)
      !udev_resp_ready |-> !udev_req_ready)
      else $error("request ready while response side stalled");

endmodule

bind umi_endpoint umi_endpoint_sva umi_endpoint_sva_i
  (.clk              (clk),
   .nreset           (nreset),
   .udev_req_ready   (udev_req_ready),
   .udev_resp_valid  (udev_resp_valid),
   .udev_resp_packet (udev_resp_packet),
   .udev_resp_ready  (udev_resp_ready));

/* src/umi_mem_top.sv */
// subsystem top: UMI endpoint in front of the local register memory on one device port
`include "umi_defines.svh"

module umi_mem_top
  (
   input  logic               clk,
   input  logic               nreset,
   // request side
   input  logic               udev_req_valid,
   input  logic [`UMI_UW-1:0] udev_req_packet,
   output logic               udev_req_ready,
   // response side
   output logic               udev_resp_valid,
   output logic [`UMI_UW-1:0] udev_resp_packet,
   input  logic               udev_resp_ready
   );

   // endpoint to memory
   mem_pkg::mem_index_t loc_index;
   logic                loc_write;
   logic [`UMI_DW-1:0]  loc_wrdata;
   logic [`UMI_DW-1:0]  loc_rddata;
   logic                loc_ready;

   umi_endpoint #(.reg_out(1'b1)) umi_endpoint_i
     (.clk              (clk),
      .nreset           (nreset),
      .udev_req_valid   (udev_req_valid),
      .udev_req_packet  (udev_req_packet),
      .udev_req_ready   (udev_req_ready),
      .udev_resp_valid  (udev_resp_valid),
      .udev_resp_packet (udev_resp_packet),
      .udev_resp_ready  (udev_resp_ready),
      .loc_index        (loc_index),
      .loc_write        (loc_write),
      .loc_read         (),             // memory reads are combinational
      .loc_wrdata       (loc_wrdata),
      .loc_rddata       (loc_rddata),
      .loc_ready        (loc_ready));

   umi_regmem umi_regmem_i
     (.clk        (clk),
      .nreset     (nreset),
      .loc_index  (loc_index),
      .loc_write  (loc_write),
      .loc_wrdata (loc_wrdata),
      .loc_rddata (loc_rddata),
      .loc_ready  (loc_ready));

endmodule

/* src/umi_regmem.sv */
// 16-word register memory, busy for one cycle after each write to model commit time
`include "umi_defines.svh"

module umi_regmem
  (
   input  logic                clk,
   input  logic                nreset,
   input  mem_pkg::mem_index_t loc_index,    // word index
   input  logic                loc_write,    // write strobe
   input  logic [`UMI_DW-1:0]  loc_wrdata,   // write data
   output logic [`UMI_DW-1:0]  loc_rddata,   // read data
   output logic                loc_ready     // low while committing
   );

   logic [`UMI_DW-1:0]  mem [`UMI_MEM_WORDS];   // storage
   mem_pkg::mem_state_e state;                 // commit state
   logic                wr_en;                 // write actually taken

   assign wr_en = loc_write & loc_ready;   // ignore strobes while busy

   //############################################################
   // busy tracking
   //############################################################

   // one busy cycle per write, a write can never follow directly
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         state <= mem_pkg::mem_idle;
      else if (wr_en)
         state <= mem_pkg::mem_busy;
      else
         state <= mem_pkg::mem_idle;
   end

   assign loc_ready = (state == mem_pkg::mem_idle);

   //############################################################
   // storage
   //############################################################

   // contents come up zero
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < `UMI_MEM_WORDS; i++)
            mem[i] <= '0;
      end
      else if (wr_en)
         mem[loc_index] <= loc_wrdata;
   end

   assign loc_rddata = mem[loc_index];   // async read

endmodule

/* src/umi_endpoint.sv */
// simple UMI endpoint: device-port requests to memory strobes, read responses held under back-pressure
`include "umi_defines.svh"

module umi_endpoint
  #(parameter bit reg_out = 1'b1)   // 1 registers the read data
  (
   input  logic                clk,
   input  logic                nreset,
   // device port
   input  logic                udev_req_valid,
   input  logic [`UMI_UW-1:0]  udev_req_packet,
   output logic                udev_req_ready,
   output logic                udev_resp_valid,
   output logic [`UMI_UW-1:0]  udev_resp_packet,
   input  logic                udev_resp_ready,
   // local memory port
   output mem_pkg::mem_index_t loc_index,    // word index
   output logic                loc_write,    // write strobe
   output logic                loc_read,     // read strobe
   output logic [`UMI_DW-1:0]  loc_wrdata,   // write data
   input  logic [`UMI_DW-1:0]  loc_rddata,   // read data, combinational
   input  logic                loc_ready     // memory not busy
   );

   // unpacked request
   logic [7:0]         req_command;
   logic [3:0]         req_size;
   logic [19:0]        req_options;
   logic [`UMI_AW-1:0] req_dstaddr;
   logic [`UMI_AW-1:0] req_srcaddr;
   logic [`UMI_DW-1:0] req_data;

   logic               is_write;    // write opcode seen
   logic               rd_accept;   // read taken this cycle

   // response payload
   logic [3:0]         size_out;
   logic [19:0]        options_out;
   logic [`UMI_AW-1:0] dstaddr_out;
   logic [`UMI_DW-1:0] resp_data;

   //############################################################
   // request decode
   //############################################################

   umi_unpack umi_unpack_i
     (.packet  (udev_req_packet),
      .command (req_command),
      .size    (req_size),
      .options (req_options),
      .dstaddr (req_dstaddr),
      .srcaddr (req_srcaddr),
      .data    (req_data));

   assign is_write = (req_command == `UMI_REQ_WRITE);   // anything else is a read

   // strobes only while the response side can take more
   assign loc_write  = is_write & udev_req_valid & udev_resp_ready;
   assign loc_read   = ~is_write & udev_req_valid & udev_resp_ready;
   assign loc_index  = mem_pkg::mem_index_t'(req_dstaddr[5:2]);   // word address
   assign loc_wrdata = req_data;

   assign udev_req_ready = loc_ready & udev_resp_ready;   // stall on busy or back-pressure
   assign rd_accept      = loc_read & loc_ready;

   //############################################################
   // response handshake
   //############################################################

   // set on accepted read, clear once taken, a new read overrides the clear
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         udev_resp_valid <= 1'b0;
      else if (rd_accept)
         udev_resp_valid <= 1'b1;
      else if (udev_resp_valid & udev_resp_ready)
         udev_resp_valid <= 1'b0;
   end

   // header and return address, only on accept so a held response stays put
   always_ff @(posedge clk)
   begin
      if (rd_accept)
      begin
         size_out    <= req_size;
         options_out <= req_options;
         dstaddr_out <= req_srcaddr;   // reply goes to the requester
      end
   end

   // optional pipestage on read data
   if (reg_out)
   begin : g_data_reg
      logic [`UMI_DW-1:0] data_out;
      always_ff @(posedge clk)
      begin
         if (rd_accept)
            data_out <= loc_rddata;   // word as it was at accept
      end
      assign resp_data = data_out;
   end
   else
   begin : g_data_comb
      assign resp_data = loc_rddata;
   end

   umi_pack umi_pack_i
     (.command (`UMI_RESP_READ),
      .size    (size_out),
      .options (options_out),
      .dstaddr (dstaddr_out),
      .srcaddr ({`UMI_AW{1'b0}}),   // endpoint has no own address
      .data    (resp_data),
      .packet  (udev_resp_packet));

endmodule

/* src/umi_pack.sv */
// response packet builder from header fields, addresses and data, combinational
`include "umi_defines.svh"

module umi_pack
  (
   input  logic [7:0]         command,   // opcode
   input  logic [3:0]         size,      // transfer size
   input  logic [19:0]        options,   // options field
   input  logic [`UMI_AW-1:0] dstaddr,   // where the packet goes
   input  logic [`UMI_AW-1:0] srcaddr,   // who sends it
   input  logic [`UMI_DW-1:0] data,      // payload
   output logic [`UMI_UW-1:0] packet     // assembled packet
   );

   umi_pkg::umi_header_u hdr;   // header, built through fields

   always_comb
   begin
      hdr.fields.command = command;
      hdr.fields.size    = size;
      hdr.fields.options = options;
   end

   // place each word in its slot
   always_comb
   begin
      packet = '0;
      packet[umi_pkg::word_lsb(umi_pkg::word_hdr) +: `UMI_DW]  = hdr.word;
      packet[umi_pkg::word_lsb(umi_pkg::word_dst) +: `UMI_AW]  = dstaddr;
      packet[umi_pkg::word_lsb(umi_pkg::word_src) +: `UMI_AW]  = srcaddr;
      packet[umi_pkg::word_lsb(umi_pkg::word_data) +: `UMI_DW] = data;
   end

endmodule

/* src/umi_unpack.sv */
// request packet decoder: header fields, addresses and data, purely combinational
`include "umi_defines.svh"

module umi_unpack
  (
   input  logic [`UMI_UW-1:0] packet,    // incoming packet
   output logic [7:0]         command,   // opcode
   output logic [3:0]         size,      // transfer size
   output logic [19:0]        options,   // options field
   output logic [`UMI_AW-1:0] dstaddr,   // target address
   output logic [`UMI_AW-1:0] srcaddr,   // requester address
   output logic [`UMI_DW-1:0] data       // write payload
   );

   umi_pkg::umi_header_u hdr;   // header word, read through fields

   //############################################################
   // header decode
   //############################################################

   assign hdr.word = packet[umi_pkg::word_lsb(umi_pkg::word_hdr) +: `UMI_DW];

   assign command = hdr.fields.command;
   assign size    = hdr.fields.size;
   assign options = hdr.fields.options;

   //############################################################
   // address and data words
   //############################################################

   assign dstaddr = packet[umi_pkg::word_lsb(umi_pkg::word_dst) +: `UMI_AW];
   assign srcaddr = packet[umi_pkg::word_lsb(umi_pkg::word_src) +: `UMI_AW];
   assign data    = packet[umi_pkg::word_lsb(umi_pkg::word_data) +: `UMI_DW];

endmodule

/* src/mem_pkg.sv */
// local memory types shared by the endpoint and the register memory
`include "umi_defines.svh"

package mem_pkg;

   // word index into local memory
   // taken from byte address bits 5 to 2
   typedef logic [$clog2(`UMI_MEM_WORDS)-1:0] mem_index_t;

   // memory commit state
   typedef enum logic {
      mem_idle = 1'b0,   // ready for a request
      mem_busy = 1'b1    // committing the last write
   } mem_state_e;

endpackage

/* src/umi_pkg.sv */
// packet layout types: header union and word slots, used by pack, unpack and the testbench
`include "umi_defines.svh"

package umi_pkg;

   // header fields, command sits in the low byte
   typedef struct packed {
      logic [19:0] options;   // transaction options
      logic [3:0]  size;      // log2 of bytes, 2 for one word
      logic [7:0]  command;   // opcode
   } umi_header_s;

   // same header word, decoded as fields or handled raw
   typedef union packed {
      umi_header_s        fields;
      logic [`UMI_DW-1:0] word;
   } umi_header_u;

   // word slots inside a packet, slot 0 in the low bits
   typedef enum logic [1:0] {
      word_hdr  = 2'd0,   // header
      word_dst  = 2'd1,   // destination address
      word_src  = 2'd2,   // source address
      word_data = 2'd3    // payload
   } umi_word_e;

   // lowest packet bit of a word slot
   function automatic int unsigned word_lsb(umi_word_e slot);
      return int'(slot) * `UMI_DW;
   endfunction

endpackage

/* src/umi_defines.svh */
// bus widths, memory depth and command codes; include in any file that sizes UMI signals
`ifndef UMI_DEFINES_SVH
`define UMI_DEFINES_SVH

//############################################################
// bus widths
//############################################################

`define UMI_AW 32     // address width
`define UMI_DW 32     // data width, also one packet word
`define UMI_UW 128    // packet: header, dst, src, data

// local register memory depth in words
`define UMI_MEM_WORDS 16

//############################################################
// command codes
//############################################################

`define UMI_REQ_WRITE 8'h03   // posted write, no response
`define UMI_REQ_READ  8'h01   // read request
`define UMI_RESP_READ 8'h21   // read response back to requester

`endif
